// File: src/memmap_pkg.sv
// ========================================
// display memory shared types
// opcodes, response kinds, pipeline structs
// ========================================
package memmap_pkg;

    // host command codes, 4 to 7 are illegal
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_WRITE = 3'd1,
        OP_READ  = 3'd2,
        OP_FILL  = 3'd3
    } opcode_e;

    typedef enum logic [1:0] {
        RSP_OK       = 2'd0,
        RSP_UNMAPPED = 2'd1,
        RSP_ILLEGAL  = 2'd2
    } rsp_kind_e;

    // count is in words, zero means one word
    typedef struct packed {
        opcode_e     opcode;
        logic [31:0] addr;
        logic [31:0] data;
        logic [15:0] count;
    } host_cmd_t;

    // decoded request, decode slot to execute
    typedef struct packed {
        logic        valid;
        logic        is_write;
        logic        is_read;
        logic        illegal;
        logic [31:0] addr;
        logic [31:0] data;
        logic [15:0] count;
    } exec_req_t;

    // travels alongside each bus cycle
    typedef struct packed {
        logic rd;
        logic illegal;
    } rd_tag_t;

    typedef struct packed {
        rsp_kind_e   kind;
        logic [31:0] rdata;
    } rsp_t;

endpackage

// File: src/sync_ram.sv
// ========================================
// single-port word RAM, registered read
// ========================================
`timescale 1ns/1ps

module sync_ram #(
    parameter int BYTES = 1024
) (
    input  logic                     clk_i,
    input  logic [$clog2(BYTES)-1:0] addr_i,
    input  logic [31:0]              wr_data_i,
    input  logic                     wr_en_i,
    output logic [31:0]              rd_data_o
);
    localparam int AW    = $clog2(BYTES);
    localparam int WORDS = BYTES / 4;

    logic [31:0]   mem [WORDS];
    logic [AW-3:0] word_idx;
    logic          in_range;

    // drop the byte offset
    assign word_idx = addr_i[AW-1:2];
    // sizes that are not a power of two leave a hole at the top
    assign in_range = (32'(word_idx) < WORDS);

    always_ff @(posedge clk_i) begin
        if (wr_en_i && in_range) begin
            mem[word_idx] <= wr_data_i;
        end
        // holes read back as zero
        rd_data_o <= in_range ? mem[word_idx] : '0;
    end

endmodule

// File: src/memory_map.sv
// ========================================
// bus address decoder for main memory,
// palette and framebuffer, with hit flag
// ========================================
`timescale 1ns/1ps

module memory_map #(
    parameter int unsigned MEMORY_BASE_ADDR      = 0,
    parameter int unsigned MEMORY_BYTES          = 1024,
    parameter int unsigned PALETTE_BASE_ADDR     = 2048,
    parameter int unsigned PALETTE_BYTES         = 512,
    parameter int unsigned FRAMEBUFFER_BASE_ADDR = 131072,
    parameter int unsigned FRAMEBUFFER_BYTES     = 120000
) (
    input  logic                                 clk_i,
    input  logic [31:0]                          bus_addr_i,
    input  logic [31:0]                          bus_wr_data_i,
    input  logic                                 bus_wr_en_i,
    output logic [31:0]                          bus_rd_data_o,
    output logic                                 bus_hit_o,
    output logic [$clog2(MEMORY_BYTES)-1:0]      mem_addr_o,
    output logic [31:0]                          mem_wr_data_o,
    output logic                                 mem_wr_en_o,
    input  logic [31:0]                          mem_rd_data_i,
    output logic [$clog2(PALETTE_BYTES)-1:0]     palette_addr_o,
    output logic [31:0]                          palette_wr_data_o,
    output logic                                 palette_wr_en_o,
    input  logic [31:0]                          palette_rd_data_i,
    output logic [$clog2(FRAMEBUFFER_BYTES)-1:0] fb_addr_o,
    output logic [31:0]                          fb_wr_data_o,
    output logic                                 fb_wr_en_o,
    input  logic [31:0]                          fb_rd_data_i
);
    localparam int MEM_AW = $clog2(MEMORY_BYTES);
    localparam int PAL_AW = $clog2(PALETTE_BYTES);
    localparam int FB_AW  = $clog2(FRAMEBUFFER_BYTES);

    localparam logic [31:0] MEM_BASE = 32'(MEMORY_BASE_ADDR);
    localparam logic [31:0] PAL_BASE = 32'(PALETTE_BASE_ADDR);
    localparam logic [31:0] FB_BASE  = 32'(FRAMEBUFFER_BASE_ADDR);

    logic [31:0] prev_addr_q;
    logic [2:0]  wr_sel;
    logic [2:0]  rd_sel;

    // one-hot {fb, palette, mem}, memory wins over palette over fb
    function automatic logic [2:0] region_sel(input logic [31:0] addr);
        logic hit_mem;
        logic hit_pal;
        logic hit_fb;
        hit_mem = (addr[31:MEM_AW] == MEM_BASE[31:MEM_AW]);
        hit_pal = (addr[31:PAL_AW] == PAL_BASE[31:PAL_AW]);
        hit_fb  = (addr[31:FB_AW] == FB_BASE[31:FB_AW]);
        region_sel = {hit_fb && !hit_mem && !hit_pal, hit_pal && !hit_mem, hit_mem};
    endfunction

    // RAM data now present belongs to last cycle's address
    always_ff @(posedge clk_i) begin
        prev_addr_q <= bus_addr_i;
    end

    assign wr_sel = region_sel(bus_addr_i);
    assign rd_sel = region_sel(prev_addr_q);

    assign mem_addr_o        = bus_addr_i[MEM_AW-1:0];
    assign mem_wr_data_o     = bus_wr_data_i;
    assign mem_wr_en_o       = bus_wr_en_i && wr_sel[0];
    assign palette_addr_o    = bus_addr_i[PAL_AW-1:0];
    assign palette_wr_data_o = bus_wr_data_i;
    assign palette_wr_en_o   = bus_wr_en_i && wr_sel[1];
    assign fb_addr_o         = bus_addr_i[FB_AW-1:0];
    assign fb_wr_data_o      = bus_wr_data_i;
    assign fb_wr_en_o        = bus_wr_en_i && wr_sel[2];

    assign bus_hit_o = |rd_sel;

    always_comb begin
        if (rd_sel[0]) begin
            bus_rd_data_o = mem_rd_data_i;
        end else if (rd_sel[1]) begin
            bus_rd_data_o = palette_rd_data_i;
        end else if (rd_sel[2]) begin
            bus_rd_data_o = fb_rd_data_i;
        end else begin
            bus_rd_data_o = '0;
        end
    end

endmodule

// File: src/cmd_decode.sv
// ========================================
// one-entry command slot, opcode decode
// ========================================
`timescale 1ns/1ps

module cmd_decode import memmap_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  host_cmd_t cmd_i,
    input  logic      cmd_valid_i,
    input  logic      take_i,
    output exec_req_t req_o,
    output logic      busy_o
);
    exec_req_t slot_q;
    exec_req_t dec_req;
    logic      accept;

    // strobes while the slot is full are dropped
    assign accept = cmd_valid_i && !slot_q.valid;

    always_comb begin
        dec_req       = '0;
        dec_req.addr  = cmd_i.addr;
        dec_req.data  = cmd_i.data;
        dec_req.count = 16'd1;
        case (cmd_i.opcode)
            OP_NOP: begin
                dec_req.valid = 1'b0;
            end
            OP_WRITE: begin
                dec_req.valid    = 1'b1;
                dec_req.is_write = 1'b1;
            end
            OP_READ: begin
                dec_req.valid   = 1'b1;
                dec_req.is_read = 1'b1;
            end
            OP_FILL: begin
                // a fill is a write repeated count times
                dec_req.valid    = 1'b1;
                dec_req.is_write = 1'b1;
                dec_req.count    = (cmd_i.count == '0) ? 16'd1 : cmd_i.count;
            end
            default: begin
                dec_req.valid   = 1'b1;
                dec_req.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_q.valid <= 1'b0;
        end else if (accept) begin
            slot_q <= dec_req;
        end else if (take_i) begin
            slot_q.valid <= 1'b0;
        end
    end

    assign req_o  = slot_q;
    assign busy_o = slot_q.valid;

endmodule

// File: src/bus_execute.sv
// ========================================
// bus driver, one access per cycle,
// repeats writes for multi-word fills
// ========================================
`timescale 1ns/1ps

module bus_execute import memmap_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  exec_req_t   req_i,
    output logic        take_o,
    output logic [31:0] bus_addr_o,
    output logic [31:0] bus_wr_data_o,
    output logic        bus_wr_en_o,
    output rd_tag_t     tag_o
);
    // words left including the one on the bus now, zero when idle
    logic [15:0] rem_q;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic        wr_q;
    logic        rd_q;
    logic        ill_q;
    logic        active;
    logic        last;

    assign active = (rem_q != '0);
    assign last   = (rem_q <= 16'd1);

    // next request starts as soon as the current one is on its last word
    assign take_o = req_i.valid && last;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rem_q <= '0;
        end else if (take_o) begin
            rem_q <= req_i.count;
        end else if (active) begin
            rem_q <= rem_q - 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            addr_q <= req_i.addr;
            data_q <= req_i.data;
            wr_q   <= req_i.is_write;
            rd_q   <= req_i.is_read;
            ill_q  <= req_i.illegal;
        end else if (!last) begin
            // step to the next word of a fill
            addr_q <= addr_q + 32'd4;
        end
    end

    assign bus_addr_o    = addr_q;
    assign bus_wr_data_o = data_q;
    assign bus_wr_en_o   = active && wr_q;

    // illegal requests use a bus cycle only to carry the tag
    assign tag_o.rd      = active && rd_q;
    assign tag_o.illegal = active && ill_q;

endmodule

// File: src/read_result.sv
// ========================================
// response stage, lines tags up with RAM
// read latency and pulses rsp_valid_o
// ========================================
`timescale 1ns/1ps

module read_result import memmap_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  rd_tag_t     tag_i,
    input  logic        bus_hit_i,
    input  logic [31:0] bus_rd_data_i,
    output rsp_t        rsp_o,
    output logic        rsp_valid_o
);
    rd_tag_t tag_q;
    rsp_t    rsp_d;

    // RAM data shows up one cycle after the bus cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag_i;
        end
    end

    always_comb begin
        if (tag_q.illegal) begin
            rsp_d.kind  = RSP_ILLEGAL;
            rsp_d.rdata = '0;
        end else begin
            rsp_d.kind  = bus_hit_i ? RSP_OK : RSP_UNMAPPED;
            rsp_d.rdata = bus_rd_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= tag_q.rd || tag_q.illegal;
        end
        rsp_o <= rsp_d;
    end

endmodule

// File: src/display_mem_top.sv
// ========================================
// display memory subsystem top level
// ========================================
`timescale 1ns/1ps

module display_mem_top import memmap_pkg::*; #(
    parameter int unsigned MEMORY_BASE_ADDR      = 0,
    parameter int unsigned MEMORY_BYTES          = 1024,
    parameter int unsigned PALETTE_BASE_ADDR     = 2048,
    parameter int unsigned PALETTE_BYTES         = 512,
    parameter int unsigned FRAMEBUFFER_BASE_ADDR = 131072,
    parameter int unsigned FRAMEBUFFER_BYTES     = 120000
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  host_cmd_t cmd_i,
    input  logic      cmd_valid_i,
    output logic      busy_o,
    output rsp_t      rsp_o,
    output logic      rsp_valid_o
);
    localparam int MEM_AW = $clog2(MEMORY_BYTES);
    localparam int PAL_AW = $clog2(PALETTE_BYTES);
    localparam int FB_AW  = $clog2(FRAMEBUFFER_BYTES);

    exec_req_t   req;
    logic        take;
    rd_tag_t     tag;

    logic [31:0] bus_addr;
    logic [31:0] bus_wr_data;
    logic        bus_wr_en;
    logic [31:0] bus_rd_data;
    logic        bus_hit;

    logic [MEM_AW-1:0] mem_addr;
    logic [31:0]       mem_wr_data;
    logic              mem_wr_en;
    logic [31:0]       mem_rd_data;
    logic [PAL_AW-1:0] palette_addr;
    logic [31:0]       palette_wr_data;
    logic              palette_wr_en;
    logic [31:0]       palette_rd_data;
    logic [FB_AW-1:0]  fb_addr;
    logic [31:0]       fb_wr_data;
    logic              fb_wr_en;
    logic [31:0]       fb_rd_data;

    cmd_decode u_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .take_i      (take),
        .req_o       (req),
        .busy_o      (busy_o)
    );

    bus_execute u_execute (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .take_o        (take),
        .bus_addr_o    (bus_addr),
        .bus_wr_data_o (bus_wr_data),
        .bus_wr_en_o   (bus_wr_en),
        .tag_o         (tag)
    );

    memory_map #(
        .MEMORY_BASE_ADDR      (MEMORY_BASE_ADDR),
        .MEMORY_BYTES          (MEMORY_BYTES),
        .PALETTE_BASE_ADDR     (PALETTE_BASE_ADDR),
        .PALETTE_BYTES         (PALETTE_BYTES),
        .FRAMEBUFFER_BASE_ADDR (FRAMEBUFFER_BASE_ADDR),
        .FRAMEBUFFER_BYTES     (FRAMEBUFFER_BYTES)
    ) u_map (
        .clk_i             (clk_i),
        .bus_addr_i        (bus_addr),
        .bus_wr_data_i     (bus_wr_data),
        .bus_wr_en_i       (bus_wr_en),
        .bus_rd_data_o     (bus_rd_data),
        .bus_hit_o         (bus_hit),
        .mem_addr_o        (mem_addr),
        .mem_wr_data_o     (mem_wr_data),
        .mem_wr_en_o       (mem_wr_en),
        .mem_rd_data_i     (mem_rd_data),
        .palette_addr_o    (palette_addr),
        .palette_wr_data_o (palette_wr_data),
        .palette_wr_en_o   (palette_wr_en),
        .palette_rd_data_i (palette_rd_data),
        .fb_addr_o         (fb_addr),
        .fb_wr_data_o      (fb_wr_data),
        .fb_wr_en_o        (fb_wr_en),
        .fb_rd_data_i      (fb_rd_data)
    );

    read_result u_result (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .tag_i         (tag),
        .bus_hit_i     (bus_hit),
        .bus_rd_data_i (bus_rd_data),
        .rsp_o         (rsp_o),
        .rsp_valid_o   (rsp_valid_o)
    );

    sync_ram #(.BYTES(MEMORY_BYTES)) u_mem (
        .clk_i     (clk_i),
        .addr_i    (mem_addr),
        .wr_data_i (mem_wr_data),
        .wr_en_i   (mem_wr_en),
        .rd_data_o (mem_rd_data)
    );

    sync_ram #(.BYTES(PALETTE_BYTES)) u_palette (
        .clk_i     (clk_i),
        .addr_i    (palette_addr),
        .wr_data_i (palette_wr_data),
        .wr_en_i   (palette_wr_en),
        .rd_data_o (palette_rd_data)
    );

    sync_ram #(.BYTES(FRAMEBUFFER_BYTES)) u_fb (
        .clk_i     (clk_i),
        .addr_i    (fb_addr),
        .wr_data_i (fb_wr_data),
        .wr_en_i   (fb_wr_en),
        .rd_data_o (fb_rd_data)
    );

endmodule

// File: dv/display_mem_assert.sv
// ========================================
// protocol and timing checks bound to the
// display memory top level
// ========================================
`timescale 1ns/1ps

module display_mem_assert import memmap_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input host_cmd_t cmd_i,
    input logic      cmd_valid_i,
    input logic      busy_i,
    input logic      take_i,
    input logic      rsp_valid_i,
    input logic      mem_wr_en_i,
    input logic      palette_wr_en_i,
    input logic      fb_wr_en_i
);
    logic any_wr_en;
    logic rsp_cmd;
    int   assert_errors = 0;

    assign any_wr_en = mem_wr_en_i || palette_wr_en_i || fb_wr_en_i;
    // reads and bad opcodes each give one response
    assign rsp_cmd = (cmd_i.opcode == OP_READ) || (3'(cmd_i.opcode) >= 3'd4);

    // quiet through reset and the first cycle after it
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !rsp_valid_i && !busy_i && !any_wr_en)
        else begin
            $error("outputs active during or right after reset");
            assert_errors++;
        end

    a_one_region: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({mem_wr_en_i, palette_wr_en_i, fb_wr_en_i}))
        else begin
            $error("more than one region write enable high");
            assert_errors++;
        end

    a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |=> !rsp_valid_i)
        else begin
            $error("rsp_valid_o held longer than one cycle");
            assert_errors++;
        end

    // execute idle, so the take follows the accept directly
    a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_valid_i && !busy_i && rsp_cmd ##1 take_i |-> ##3 rsp_valid_i)
        else begin
            $error("no response three edges after an accepted read or bad opcode");
            assert_errors++;
        end

endmodule

bind display_mem_top display_mem_assert u_assert (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .busy_i          (busy_o),
    .take_i          (take),
    .rsp_valid_i     (rsp_valid_o),
    .mem_wr_en_i     (mem_wr_en),
    .palette_wr_en_i (palette_wr_en),
    .fb_wr_en_i      (fb_wr_en)
);

// File: dv/tb_display_mem.sv
// ========================================
// display memory testbench, directed and
// random commands against an address model
// ========================================
`timescale 1ns/1ps

module tb_display_mem import memmap_pkg::*; ();
    localparam logic [31:0] MEM_BASE   = 32'd0;
    localparam int          MEM_BYTES  = 1024;
    localparam logic [31:0] PAL_BASE   = 32'd2048;
    localparam int          PAL_BYTES  = 512;
    localparam logic [31:0] FB_BASE    = 32'd131072;
    localparam int          FB_BYTES   = 120000;
    localparam int          TIMEOUT    = 200;
    localparam int          SEED       = 79680;

    logic       clk_i;
    logic       rst_n_i;
    host_cmd_t  cmd_i;
    logic       cmd_valid_i;
    logic       busy_o;
    rsp_t       rsp_o;
    logic       rsp_valid_o;

    int          check_errors;
    int          timeout_errors;
    rsp_t        exp_q[$];
    logic [31:0] written_q[$];
    // keyed by region * 65536 + word
    logic [31:0] model_mem[int];

    display_mem_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .busy_o      (busy_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic bit in_span(input logic [31:0] addr, input logic [31:0] base,
                                   input int bytes);
        logic [31:0] span;
        span = 32'd1 << $clog2(bytes);
        return (addr / span) == (base / span);
    endfunction

    // 0 memory, 1 palette, 2 framebuffer, -1 nothing
    function automatic int region_of(input logic [31:0] addr);
        if (in_span(addr, MEM_BASE, MEM_BYTES)) return 0;
        if (in_span(addr, PAL_BASE, PAL_BYTES)) return 1;
        if (in_span(addr, FB_BASE, FB_BYTES)) return 2;
        return -1;
    endfunction

    function automatic int region_bytes(input int r);
        case (r)
            0:       return MEM_BYTES;
            1:       return PAL_BYTES;
            default: return FB_BYTES;
        endcase
    endfunction

    function automatic int word_of(input logic [31:0] addr, input int r);
        logic [31:0] span;
        span = 32'd1 << $clog2(region_bytes(r));
        return int'((addr % span) >> 2);
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
        int r;
        int w;
        r = region_of(addr);
        if (r < 0) return;
        w = word_of(addr, r);
        // top of the framebuffer span has no storage
        if (w >= region_bytes(r) / 4) return;
        model_mem[r * 65536 + w] = data;
        written_q.push_back(addr);
    endfunction

    function automatic rsp_t model_read(input logic [31:0] addr);
        rsp_t exp;
        int   r;
        int   key;
        exp.kind  = RSP_UNMAPPED;
        exp.rdata = '0;
        r = region_of(addr);
        if (r >= 0) begin
            exp.kind = RSP_OK;
            key = r * 65536 + word_of(addr, r);
            if (model_mem.exists(key)) exp.rdata = model_mem[key];
        end
        return exp;
    endfunction

    // gaps between regions and the framebuffer hole
    function automatic logic [31:0] unbacked_addr();
        case ($urandom_range(0, 3))
            0:       return 32'd1024 + $urandom_range(0, 1023);
            1:       return 32'd2560 + $urandom_range(0, 128511);
            2:       return 32'd262144 + $urandom_range(0, 32'h0fff_0000);
            default: return 32'd251072 + $urandom_range(0, 11071);
        endcase
    endfunction

    function automatic logic [31:0] random_addr();
        case ($urandom_range(0, 3))
            0:       return MEM_BASE + $urandom_range(0, MEM_BYTES - 1);
            1:       return PAL_BASE + $urandom_range(0, PAL_BYTES - 1);
            2:       return FB_BASE + $urandom_range(0, 131071);
            default: return unbacked_addr();
        endcase
    endfunction

    function automatic logic [31:0] known_addr();
        logic [31:0] a;
        if (written_q.size() == 0) return unbacked_addr();
        a = written_q[$urandom_range(0, written_q.size() - 1)];
        // any byte offset selects the same word
        return {a[31:2], 2'($urandom_range(0, 3))};
    endfunction

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (busy_o && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (busy_o) begin
            $display("timeout waiting for busy_o to fall");
            timeout_errors++;
        end
    endtask

    task automatic send_cmd(input opcode_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [15:0] count);
        rsp_t ill;
        int   words;
        wait_not_busy();
        cmd_i.opcode = op;
        cmd_i.addr   = addr;
        cmd_i.data   = data;
        cmd_i.count  = count;
        cmd_valid_i  = 1'b1;
        @(posedge clk_i);
        #1;
        cmd_valid_i = 1'b0;
        case (op)
            OP_NOP: begin
            end
            OP_WRITE: model_write(addr, data);
            OP_READ:  exp_q.push_back(model_read(addr));
            OP_FILL: begin
                words = (count == '0) ? 1 : int'(count);
                for (int i = 0; i < words; i++) model_write(addr + 32'(i) * 4, data);
            end
            default: begin
                ill.kind  = RSP_ILLEGAL;
                ill.rdata = '0;
                exp_q.push_back(ill);
            end
        endcase
    endtask

    // strobe while the slot is full, dropped by the DUT
    task automatic present_ignored(input logic [31:0] addr);
        cmd_i.opcode = OP_READ;
        cmd_i.addr   = addr;
        cmd_valid_i  = 1'b1;
        @(posedge clk_i);
        #1;
        cmd_valid_i = 1'b0;
    endtask

    task automatic drain_responses();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for %0d responses", exp_q.size());
            timeout_errors++;
            exp_q.delete();
        end
    endtask

    task automatic check_region(input logic [31:0] base, input int bytes);
        logic [31:0] top;
        top = base + 32'(bytes) - 32'd4;
        send_cmd(OP_WRITE, base, base ^ 32'h5a00_00c3, '0);
        send_cmd(OP_READ, base, '0, '0);
        send_cmd(OP_WRITE, top, top ^ 32'h3c00_0f0f, '0);
        send_cmd(OP_READ, top, '0, '0);
        // byte offset two aliases onto the same word
        send_cmd(OP_WRITE, base + 32'd4, 32'hdead_0004 ^ base, '0);
        send_cmd(OP_READ, base + 32'd6, '0, '0);
        drain_responses();
    endtask

    task automatic check_unmapped();
        send_cmd(OP_READ, 32'd4096, '0, '0);
        send_cmd(OP_WRITE, 32'd4096, 32'hbad0_1000, '0);
        send_cmd(OP_WRITE, 32'd1024, 32'hbad0_0400, '0);
        send_cmd(OP_WRITE, 32'd2560, 32'hbad0_0a00, '0);
        send_cmd(OP_WRITE, 32'd262144, 32'hbad4_0000, '0);
        send_cmd(OP_READ, MEM_BASE, '0, '0);
        send_cmd(OP_READ, PAL_BASE, '0, '0);
        send_cmd(OP_READ, FB_BASE, '0, '0);
        send_cmd(OP_READ, FB_BASE + 32'(FB_BYTES), '0, '0);
        drain_responses();
    endtask

    task automatic check_fill(input logic [31:0] start, input logic [15:0] n);
        send_cmd(OP_WRITE, start + 32'(n) * 4, 32'hc0de_0000 ^ start, '0);
        send_cmd(OP_FILL, start, 32'h0f11_0000 | 32'(n), n);
        send_cmd(OP_READ, start, '0, '0);
        present_ignored(start + 32'd4);
        // the read still waits behind the fill
        assert (busy_o == 1'b1) else begin
            $display("ERR busy_o got %h exp %h", busy_o, 1'b1);
            check_errors++;
        end
        for (int i = 1; i <= int'(n); i++) send_cmd(OP_READ, start + 32'(i) * 4, '0, '0);
        drain_responses();
    endtask

    task automatic check_illegal();
        for (int op = 4; op < 8; op++) send_cmd(opcode_e'(3'(op)), 32'h100, '0, '0);
        send_cmd(OP_NOP, 32'h100, '0, '0);
        drain_responses();
        // window for any stray response
        repeat (8) @(posedge clk_i);
        #1;
    endtask

    task automatic run_random(input int n);
        int          choice;
        logic [31:0] data;
        for (int i = 0; i < n; i++) begin
            choice = int'($urandom_range(0, 9));
            data   = $urandom();
            if (choice < 4) begin
                send_cmd(OP_WRITE, random_addr(), data, '0);
            end else if (choice < 7) begin
                send_cmd(OP_READ, known_addr(), '0, '0);
            end else if (choice < 9) begin
                send_cmd(OP_FILL, random_addr(), data, 16'($urandom_range(0, 4)));
            end else begin
                send_cmd(OP_READ, unbacked_addr(), '0, '0);
            end
        end
        drain_responses();
    endtask

    // responses come back in command order
    always @(posedge clk_i) begin
        rsp_t exp;
        if (rst_n_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response on rsp_o");
                check_errors++;
            end else begin
                exp = exp_q.pop_front();
                assert (rsp_o.kind == exp.kind) else begin
                    $display("ERR rsp_o.kind got %h exp %h", rsp_o.kind, exp.kind);
                    check_errors++;
                end
                assert (rsp_o.rdata == exp.rdata) else begin
                    $display("ERR rsp_o.rdata got %h exp %h", rsp_o.rdata, exp.rdata);
                    check_errors++;
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        cmd_i          = '0;
        cmd_valid_i    = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        check_region(MEM_BASE, MEM_BYTES);
        check_region(PAL_BASE, PAL_BYTES);
        check_region(FB_BASE, FB_BYTES);
        check_unmapped();
        check_fill(PAL_BASE + 32'd64, 16'd8);
        check_fill(FB_BASE + 32'd4000, 16'd12);
        check_illegal();
        run_random(300);
        repeat (8) @(posedge clk_i);

        $display("errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, DUT.u_assert.assert_errors);
        if (check_errors == 0 && timeout_errors == 0 &&
            DUT.u_assert.assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/memmap_pkg.sv
src/sync_ram.sv
src/memory_map.sv
src/cmd_decode.sv
src/bus_execute.sv
src/read_result.sv
src/display_mem_top.sv
dv/display_mem_assert.sv
dv/tb_display_mem.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_display_mem \
    -f vlog.f -Mdir obj_dir -o sim_display_mem > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_display_mem > sim.log 2>&1
cat sim.log
grep -q "^TEST PASS$" sim.log && exit 0 || { echo "simulation failed"; exit 1; }
